/* hw/hazard_consts.svh */
// widths, never-used Tuse value and multiply/divide busy durations
// for the hazard control pipeline

`ifndef HAZARD_CONSTS_SVH
`define HAZARD_CONSTS_SVH

// instruction word and register address
`define WIDTH_INSTR 32
`define WIDTH_REG   5

// Tuse / Tnew counters
`define WIDTH_T     2
`define TUSE_INF    3   // source never read

// multiply/divide unit occupancy, in cycles
`define MULT_CYCLES 5
`define DIV_CYCLES  10
`define WIDTH_MDCNT 4

`endif

/* hw/hazard_pkg.sv */
// instruction class and md op enums
// decode result and pipeline stage payload structs

`default_nettype none

`include "hazard_consts.svh"

package hazard_pkg;

    typedef enum logic [2:0] {
        CLS_CALC_R    = 3'd0,
        CLS_CALC_I    = 3'd1,
        CLS_MEM_READ  = 3'd2,
        CLS_MEM_WRITE = 3'd3,
        CLS_BRANCH    = 3'd4,
        CLS_JUMP      = 3'd5,
        CLS_MULTDIV   = 3'd6,
        CLS_NOP       = 3'd7
    } instr_class_e;

    // op that occupies the multiply/divide unit
    typedef enum logic [1:0] {
        MD_NONE = 2'd0,
        MD_MULT = 2'd1,
        MD_DIV  = 2'd2
    } md_op_e;

    typedef struct packed {
        instr_class_e          cls;
        md_op_e                md_op;
        logic [`WIDTH_REG-1:0] rs;
        logic [`WIDTH_REG-1:0] rt;
        logic [`WIDTH_REG-1:0] dest;     // 0 when nothing is written
        logic [`WIDTH_T-1:0]   tuse_rs;
        logic [`WIDTH_T-1:0]   tuse_rt;
        logic [`WIDTH_T-1:0]   tnew;     // as seen at ID
    } decode_t;

    // EX and MEM entry
    typedef struct packed {
        logic                  valid;
        md_op_e                md_op;
        logic [`WIDTH_REG-1:0] dest;
        logic [`WIDTH_T-1:0]   tnew;
    } stage_t;

    typedef struct packed {
        logic                  valid;
        logic [`WIDTH_REG-1:0] dest;
        logic [`WIDTH_T-1:0]   tnew;
    } wb_t;

endpackage

`default_nettype wire

/* hw/instr_decoder.sv */
// instr_decoder: class, register fields, destination and Tuse/Tnew per instruction

`default_nettype none
`timescale 1ns/1ps

`include "hazard_consts.svh"

module instr_decoder
    import hazard_pkg::*;
(
    input  logic [`WIDTH_INSTR-1:0] instr,
    output decode_t                 dec
);
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_MFLO = 6'h12;
    localparam logic [5:0] FN_MTLO = 6'h13;
    localparam logic [5:0] FN_MULT = 6'h18;
    localparam logic [5:0] FN_DIV  = 6'h1a;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;

    localparam logic [`WIDTH_T-1:0] T_INF = `WIDTH_T'(`TUSE_INF);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [`WIDTH_REG-1:0] rs;
    logic [`WIDTH_REG-1:0] rt;
    logic [`WIDTH_REG-1:0] rd;
    logic [`WIDTH_REG-1:0] dest;
    instr_class_e          cls;
    md_op_e                md_op;
    logic                  is_sll;
    logic                  is_lui;
    logic                  is_jal;
    logic                  is_jr;
    logic                  is_mflo;
    logic [`WIDTH_T-1:0]   tuse_rs;
    logic [`WIDTH_T-1:0]   tuse_rt;
    logic [`WIDTH_T-1:0]   tnew;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];

    always_comb begin
        cls     = CLS_NOP;   // all-zero word and unknown opcodes
        md_op   = MD_NONE;
        dest    = '0;
        is_sll  = 1'b0;
        is_lui  = 1'b0;
        is_jal  = 1'b0;
        is_jr   = 1'b0;
        is_mflo = 1'b0;
        if (instr != '0) begin
            case (opcode)
                OP_SPECIAL: begin
                    case (funct)
                        FN_ADDU, FN_SUBU: begin cls = CLS_CALC_R; dest = rd; end
                        FN_SLL:  begin cls = CLS_CALC_R; dest = rd; is_sll = 1'b1; end
                        FN_JR:   begin cls = CLS_JUMP; is_jr = 1'b1; end
                        FN_MULT: begin cls = CLS_MULTDIV; md_op = MD_MULT; end
                        FN_DIV:  begin cls = CLS_MULTDIV; md_op = MD_DIV; end
                        FN_MFLO: begin cls = CLS_MULTDIV; dest = rd; is_mflo = 1'b1; end
                        FN_MTLO: cls = CLS_MULTDIV;
                        default: ;
                    endcase
                end
                OP_ORI:  begin cls = CLS_CALC_I; dest = rt; end
                OP_LUI:  begin cls = CLS_CALC_I; dest = rt; is_lui = 1'b1; end
                OP_LW:   begin cls = CLS_MEM_READ; dest = rt; end
                OP_SW:   cls = CLS_MEM_WRITE;
                OP_BEQ:  cls = CLS_BRANCH;
                OP_JAL:  begin cls = CLS_JUMP; dest = `WIDTH_REG'(31); is_jal = 1'b1; end
                default: ;
            endcase
        end
    end

    assign tuse_rs =
        (cls == CLS_CALC_R)    ? (is_sll ? T_INF : `WIDTH_T'(1)) :
        (cls == CLS_CALC_I)    ? (is_lui ? T_INF : `WIDTH_T'(1)) :
        (cls == CLS_MEM_READ)  ? `WIDTH_T'(1) :
        (cls == CLS_MEM_WRITE) ? `WIDTH_T'(1) :
        (cls == CLS_BRANCH)    ? `WIDTH_T'(0) :
        (cls == CLS_JUMP)      ? (is_jr ? `WIDTH_T'(0) : T_INF) :
        (cls == CLS_MULTDIV)   ? (is_mflo ? T_INF : `WIDTH_T'(1)) :
        T_INF;

    assign tuse_rt =
        (cls == CLS_CALC_R)    ? `WIDTH_T'(1) :
        (cls == CLS_MEM_WRITE) ? `WIDTH_T'(2) :   // store data needed in MEM
        (cls == CLS_BRANCH)    ? `WIDTH_T'(0) :
        (cls == CLS_MULTDIV)   ? ((md_op != MD_NONE) ? `WIDTH_T'(1) : T_INF) :
        T_INF;

    assign tnew =
        (cls == CLS_CALC_R)   ? `WIDTH_T'(2) :
        (cls == CLS_CALC_I)   ? (is_lui ? `WIDTH_T'(1) : `WIDTH_T'(2)) :
        (cls == CLS_MEM_READ) ? `WIDTH_T'(3) :
        (cls == CLS_JUMP)     ? (is_jal ? `WIDTH_T'(1) : `WIDTH_T'(0)) :
        (cls == CLS_MULTDIV)  ? (is_mflo ? `WIDTH_T'(2) : `WIDTH_T'(0)) :
        `WIDTH_T'(0);

    assign dec = '{cls: cls, md_op: md_op, rs: rs, rt: rt, dest: dest,
                   tuse_rs: tuse_rs, tuse_rt: tuse_rt, tnew: tnew};

endmodule

`default_nettype wire

/* hw/stage_slot.sv */
// pipeline register for any stage payload
// with bubble insert and saturating Tnew countdown

`default_nettype none
`timescale 1ns/1ps

`include "hazard_consts.svh"

module stage_slot
    import hazard_pkg::*;
#(
    parameter type payload_t = stage_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);
    payload_t loaded;

    always_comb begin
        loaded = d;
        if (d.tnew != '0) begin
            loaded.tnew = d.tnew - `WIDTH_T'(1);   // one stage closer to the result
        end
    end

    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            q <= '0;
        end else begin
            q <= loaded;
        end
    end

    // an empty entry carries no destination and no pending result
    a_empty_clear: assert property (@(posedge clk) disable iff (rst)
        !q.valid |-> (q.dest == '0 && q.tnew == '0))
        else $error("empty stage entry carries a result");

endmodule

`default_nettype wire

/* hw/md_cycle_counter.sv */
// md_cycle_counter: loadable down-counter, flags last busy cycle

`default_nettype none
`timescale 1ns/1ps

`include "hazard_consts.svh"

module md_cycle_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  logic [`WIDTH_MDCNT-1:0] count,
    output logic                    last
);
    logic [`WIDTH_MDCNT-1:0] remain;

    always_ff @(posedge clk) begin
        if (rst) begin
            remain <= '0;
        end else if (load) begin
            remain <= count;
        end else if (remain != '0) begin
            remain <= remain - `WIDTH_MDCNT'(1);
        end
    end

    assign last = (remain == `WIDTH_MDCNT'(1));

    // fsm only reloads once the previous run has drained
    a_no_early_load: assert property (@(posedge clk) disable iff (rst)
        load |-> remain <= `WIDTH_MDCNT'(1))
        else $error("counter reloaded while still running");

endmodule

`default_nettype wire

/* hw/md_busy_fsm.sv */
// md_busy_fsm: idle/busy tracking of the multiply/divide unit

`default_nettype none
`timescale 1ns/1ps

`include "hazard_consts.svh"

module md_busy_fsm
    import hazard_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  md_op_e start_op,
    output logic   busy
);
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_BUSY = 1'b1
    } state_e;

    state_e                  state;
    logic                    load;
    logic                    last;
    logic [`WIDTH_MDCNT-1:0] count;

    assign load  = (state == ST_IDLE) && (start_op != MD_NONE);
    assign count = (start_op == MD_DIV) ? `WIDTH_MDCNT'(`DIV_CYCLES)
                                        : `WIDTH_MDCNT'(`MULT_CYCLES);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    md_cycle_counter u_cnt (
        .clk   (clk),
        .rst   (rst),
        .load  (load),
        .count (count),
        .last  (last)
    );

    assign busy = (state == ST_BUSY);

    // interlock sees busy one edge late, so only the op right behind the
    // starting one can reach EX during busy time
    a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
        (state == ST_BUSY && start_op != MD_NONE) |-> $past(state) == ST_IDLE)
        else $error("md op entered EX deep into busy time");

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
// hazard_unit: Tuse/Tnew stall decision and multiply/divide interlock

`default_nettype none
`timescale 1ns/1ps

`include "hazard_consts.svh"

module hazard_unit
    import hazard_pkg::*;
(
    input  decode_t dec_id,
    input  stage_t  ex,
    input  stage_t  mem,
    input  logic    md_busy,
    output logic    stall
);
    // producer in a stage not ready before the consumer needs it
    function automatic logic late_result(
        input stage_t                s,
        input logic [`WIDTH_REG-1:0] src,
        input logic [`WIDTH_T-1:0]   tuse
    );
        late_result = s.valid && (s.dest == src) && (s.tnew > tuse);
    endfunction

    logic stall_rs;
    logic stall_rt;
    logic stall_md;

    // $0 is never written
    assign stall_rs = (dec_id.rs != '0) && (
        late_result(ex, dec_id.rs, dec_id.tuse_rs) ||
        late_result(mem, dec_id.rs, dec_id.tuse_rs)
    );

    assign stall_rt = (dec_id.rt != '0) && (
        late_result(ex, dec_id.rt, dec_id.tuse_rt) ||
        late_result(mem, dec_id.rt, dec_id.tuse_rt)
    );

    assign stall_md = md_busy && (dec_id.cls == CLS_MULTDIV);   // hi/lo in use

    // pc hold, id hold and ex flush all share this level
    assign stall = stall_rs || stall_rt || stall_md;

endmodule

`default_nettype wire

/* hw/hazard_top.sv */
// decoder, hazard unit, EX/MEM/WB slots and md busy controller

`default_nettype none
`timescale 1ns/1ps

`include "hazard_consts.svh"

module hazard_top
    import hazard_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`WIDTH_INSTR-1:0] instr,
    output logic                    stall,
    output logic                    md_busy,
    output logic                    wb_valid,
    output logic [`WIDTH_REG-1:0]   wb_dest
);
    decode_t dec_id;
    stage_t  ex_d;
    stage_t  ex_q;
    stage_t  mem_q;
    wb_t     wb_d;
    wb_t     wb_q;

    instr_decoder u_dec (
        .instr (instr),
        .dec   (dec_id)
    );

    hazard_unit u_hazard (
        .dec_id  (dec_id),
        .ex      (ex_q),
        .mem     (mem_q),
        .md_busy (md_busy),
        .stall   (stall)
    );

    assign ex_d = '{valid: 1'b1, md_op: dec_id.md_op, dest: dec_id.dest, tnew: dec_id.tnew};

    stage_slot #(.payload_t(stage_t)) ex_slot (
        .clk    (clk),
        .rst    (rst),
        .bubble (stall),   // stalled instr stays at ID
        .d      (ex_d),
        .q      (ex_q)
    );

    stage_slot #(.payload_t(stage_t)) mem_slot (
        .clk    (clk),
        .rst    (rst),
        .bubble (1'b0),
        .d      (ex_q),
        .q      (mem_q)
    );

    assign wb_d = '{valid: mem_q.valid, dest: mem_q.dest, tnew: mem_q.tnew};

    stage_slot #(.payload_t(wb_t)) wb_slot (
        .clk    (clk),
        .rst    (rst),
        .bubble (1'b0),
        .d      (wb_d),
        .q      (wb_q)
    );

    // bubbles carry MD_NONE, so only real md ops start the unit
    md_busy_fsm u_md (
        .clk      (clk),
        .rst      (rst),
        .start_op (ex_q.md_op),
        .busy     (md_busy)
    );

    assign wb_valid = wb_q.valid;
    assign wb_dest  = wb_q.dest;

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// tb_clock_gen: free-running clock and power-on reset

`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,   // 4 ns clock
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* verification/hazard_tb.sv */
// random MIPS subset stream against a cycle model of
// the stall, writeback and multiply/divide busy behavior

`default_nettype none
`timescale 1ns/1ps

`include "hazard_consts.svh"

module hazard_tb;
    localparam int NUM_INSTR     = 2000;
    localparam int MAX_HOLD      = 32;
    localparam int RESET_TIMEOUT = 100;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic        stall;
    logic        md_busy;
    logic        wb_valid;
    logic [4:0]  wb_dest;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          accepted;
    int          wb_pulses;
    int          hold_run;
    int          busy_cnt;
    int          snapshot;
    int          wait_cnt;
    logic        m_stall;
    logic        held;
    logic        timed_out;

    // model of the instruction at ID
    logic [4:0] id_rs, id_rt, id_dest;
    logic [1:0] id_tuse_rs, id_tuse_rt, id_tnew, id_md;
    logic       id_mdcls;

    // model stage entries
    logic       ex_v, mem_v, wbm_v;
    logic [4:0] ex_dest, mem_dest, wbm_dest;
    logic [1:0] ex_tnew, mem_tnew, ex_md;

    tb_clock_gen clkgen (.clk(clk), .rst(rst));

    hazard_top DUT (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .stall    (stall),
        .md_busy  (md_busy),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns %s: got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [1:0] dec_sat(input logic [1:0] t);
        dec_sat = (t == 2'd0) ? 2'd0 : t - 2'd1;
    endfunction

    function automatic logic src_late(input logic [4:0] src, input logic [1:0] tuse);
        src_late = (src != 5'd0) &&
                   ((ex_v && ex_dest == src && ex_tnew > tuse) ||
                    (mem_v && mem_dest == src && mem_tnew > tuse));
    endfunction

    // random class with registers 0..3 so dependences show up often
    task automatic pick_instr;
        logic [31:0] sel, rs, rt, rd, sh, imm;
        take_bits(4, sel);
        take_bits(2, rs);
        take_bits(2, rt);
        take_bits(2, rd);
        take_bits(5, sh);
        take_bits(16, imm);
        id_dest    = 5'd0;
        id_tuse_rs = 2'd3;   // not read
        id_tuse_rt = 2'd3;
        id_tnew    = 2'd0;
        id_md      = 2'd0;
        id_mdcls   = 1'b0;
        case (sel[3:0])
            4'd0, 4'd15, 4'd1: begin   // addu twice as likely
                instr = {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0,
                         (sel[3:0] == 4'd1) ? 6'h23 : 6'h21};
                id_dest    = rd[4:0];
                id_tuse_rs = 2'd1;
                id_tuse_rt = 2'd1;
                id_tnew    = 2'd2;
            end
            4'd2: begin   // sll
                instr = {6'h00, 5'd0, rt[4:0], rd[4:0], sh[4:0], 6'h00};
                id_dest    = rd[4:0];
                id_tuse_rt = 2'd1;
                id_tnew    = 2'd2;
            end
            4'd3: begin
                instr = {6'h0d, rs[4:0], rt[4:0], imm[15:0]};
                id_dest    = rt[4:0];
                id_tuse_rs = 2'd1;
                id_tnew    = 2'd2;
            end
            4'd4: begin
                instr = {6'h0f, 5'd0, rt[4:0], imm[15:0]};
                id_dest = rt[4:0];
                id_tnew = 2'd1;
            end
            4'd5: begin   // lw result only after MEM
                instr = {6'h23, rs[4:0], rt[4:0], imm[15:0]};
                id_dest    = rt[4:0];
                id_tuse_rs = 2'd1;
                id_tnew    = 2'd3;
            end
            4'd6: begin
                instr = {6'h2b, rs[4:0], rt[4:0], imm[15:0]};
                id_tuse_rs = 2'd1;
                id_tuse_rt = 2'd2;
            end
            4'd7: begin
                instr = {6'h04, rs[4:0], rt[4:0], imm[15:0]};
                id_tuse_rs = 2'd0;
                id_tuse_rt = 2'd0;
            end
            4'd8: begin
                instr = {6'h03, 10'd0, imm[15:0]};
                id_dest = 5'd31;
                id_tnew = 2'd1;
            end
            4'd9: begin
                instr = {6'h00, rs[4:0], 15'd0, 6'h08};
                id_tuse_rs = 2'd0;
            end
            4'd10, 4'd11: begin   // mult / div
                instr = {6'h00, rs[4:0], rt[4:0], 10'd0, (sel[3:0] == 4'd10) ? 6'h18 : 6'h1a};
                id_tuse_rs = 2'd1;
                id_tuse_rt = 2'd1;
                id_mdcls   = 1'b1;
                id_md      = (sel[3:0] == 4'd10) ? 2'd1 : 2'd2;
            end
            4'd12: begin
                instr = {6'h00, 10'd0, rd[4:0], 5'd0, 6'h12};
                id_dest  = rd[4:0];
                id_tnew  = 2'd2;
                id_mdcls = 1'b1;
            end
            4'd13: begin
                instr = {6'h00, rs[4:0], 15'd0, 6'h13};
                id_tuse_rs = 2'd1;
                id_mdcls   = 1'b1;
            end
            default: instr = 32'd0;
        endcase
        if (instr == 32'd0) begin   // sll $0,$0,0 is a nop
            id_dest    = 5'd0;
            id_tnew    = 2'd0;
            id_tuse_rs = 2'd3;
            id_tuse_rt = 2'd3;
        end
        id_rs = instr[25:21];
        id_rt = instr[20:16];
    endtask

    // check outputs, drive ID, check stall and step the model over one edge
    task automatic run_cycle;
        check_eq(32'(md_busy), 32'(busy_cnt != 0), "md_busy");
        check_eq(32'(wb_valid), 32'(wbm_v), "wb_valid");
        check_eq(32'(wb_dest), 32'(wbm_dest), "wb_dest");
        if (wb_valid) wb_pulses++;
        if (!held) pick_instr();
        #1;
        m_stall = src_late(id_rs, id_tuse_rs) || src_late(id_rt, id_tuse_rt) ||
                  (busy_cnt != 0 && id_mdcls);
        check_eq(32'(stall), 32'(m_stall), "stall");
        held = m_stall;
        hold_run = held ? hold_run + 1 : 0;
        if (hold_run > MAX_HOLD && !timed_out) begin
            $display("instruction held at ID past the timeout");
            timed_out = 1'b1;
        end
        if (busy_cnt != 0) busy_cnt--;
        else if (ex_v && ex_md == 2'd1) busy_cnt = `MULT_CYCLES;
        else if (ex_v && ex_md == 2'd2) busy_cnt = `DIV_CYCLES;
        wbm_v    = mem_v;
        wbm_dest = mem_dest;
        mem_v    = ex_v;
        mem_dest = ex_dest;
        mem_tnew = dec_sat(ex_tnew);
        if (m_stall) begin
            ex_v    = 1'b0;
            ex_dest = 5'd0;
            ex_tnew = 2'd0;
            ex_md   = 2'd0;
        end else begin
            ex_v    = 1'b1;
            ex_dest = id_dest;
            ex_tnew = dec_sat(id_tnew);
            ex_md   = id_md;
            accepted++;
        end
        @(negedge clk);
    endtask

    initial begin
        instr = 32'd0;
        lfsr = 32'h273e7c2d;
        {errors, checks, accepted, wb_pulses, hold_run, busy_cnt, snapshot, wait_cnt} = '0;
        {ex_v, mem_v, wbm_v, ex_dest, mem_dest, wbm_dest} = '0;
        {ex_tnew, mem_tnew, ex_md} = '0;
        held = 1'b0;
        timed_out = 1'b0;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (rst && wait_cnt < RESET_TIMEOUT);
        if (rst) begin
            $display("reset was never released");
            timed_out = 1'b1;
        end else begin
            check_eq(32'(md_busy), 32'd0, "md_busy after reset");
            check_eq(32'(wb_valid), 32'd0, "wb_valid after reset");
            check_eq(32'(stall), 32'd0, "stall with nop after reset");
            while (accepted < NUM_INSTR && !timed_out) run_cycle();
            if (!timed_out) begin
                snapshot = accepted;
                repeat (3) run_cycle();   // drain to WB
                check_eq(32'(wb_pulses), 32'(snapshot), "wb pulses vs accepted instructions");
            end
        end
        $display("%0d instructions, %0d checks, %0d errors", snapshot, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hazard_top.f */
+incdir+hw
hw/hazard_pkg.sv
hw/instr_decoder.sv
hw/stage_slot.sv
hw/md_cycle_counter.sv
hw/md_busy_fsm.sv
hw/hazard_unit.sv
hw/hazard_top.sv
verification/tb_clock_gen.sv
verification/hazard_tb.sv

/* Makefile */
# Verilator flow for the hazard control testbench

VERILATOR ?= verilator
TOP       ?= hazard_tb
FILELIST  ?= hazard_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit code of the binary
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
